/* tb.f */
+incdir+hdl
hdl/funnelPkg.sv
hdl/enqQueue.sv
hdl/funnelLevel.sv
hdl/funnelTree.sv
hdl/funnelTop.sv
sim/funnelTb.sv

/* Makefile */
# Verilator build for the funnel project

VERILATOR  := verilator
TOP        := funnelTb
RTL_TOP    := funnelTop
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Simulation finished: PASS
LINT_FLAGS := --lint-only -Wall --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# The log decides the result, so a failing run makes grep return an error
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/funnelTb.sv */
// Funnel testbench that drives the producer ports from a step table and checks the merged stream
`timescale 1ns/1ns
`include "funnel_settings.svh"

module funnelTb import funnelPkg::*; ();

    localparam int numRows = 13;
    localparam int numTests = 5;

    typedef enum logic [1:0] {rdyAlways, rdyNever, rdyRandom} rdyMode;

    // One step of stimulus; the ports in mask offer a new word every cycle for the given count
    typedef struct packed {
        logic [2:0] testId;
        logic [7:0] mask;
        logic       randomMask;
        dataWord    seedMix;
        rdyMode     rdy;
        logic [7:0] cycles;
        logic       timed;
        logic       ordered;
        logic       countAccepts;
        queueCount  expAccepted;
        logic       drain;
    } stepRow;

    // Word the model expects from one port, with the cycle it was accepted in
    typedef struct packed {
        dataWord data;
        int      cycle;
        logic    timed;
        logic    ordered;
    } expRecord;

    logic      CLK;
    logic      reset;
    logic      inEna  [`FUNNEL_WIDTH];
    dataWord   inData [`FUNNEL_WIDTH];
    logic      inRdy  [`FUNNEL_WIDTH];
    logic      outEna;
    funnelItem outItem;
    logic      outRdy;

    stepRow    steps [numRows];
    string     testName [numTests];
    expRecord  expQ [`FUNNEL_WIDTH][$];
    sourceTag  orderQ [$];
    logic      pending [`FUNNEL_WIDTH];
    dataWord   pendWord [`FUNNEL_WIDTH];
    int        seq [`FUNNEL_WIDTH];
    integer    seed;
    int        cycle;
    int        checks;
    int        errors;
    int        itemsOut;
    int        rowAccepted;
    logic      prevStall;
    funnelItem prevItem;

    funnelTop i_funnelTop (
        .CLK    (CLK),
        .reset  (reset),
        .inEna  (inEna),
        .inData (inData),
        .inRdy  (inRdy),
        .outEna (outEna),
        .outItem(outItem),
        .outRdy (outRdy)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    task automatic checkTag(input string name, input sourceTag expected, input sourceTag actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic checkWord(input string name, input dataWord expected, input dataWord actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(input string name, input queueCount expected,
                              input queueCount actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic noteFailure(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // Port index in the top bits and a running number per port keep words unique
    function automatic dataWord makeWord(input int k, input dataWord mix);
        dataWord word;
        word = {4'(k), 12'(seq[k]), 16'($random(seed))} ^ mix;
        seq[k]++;
        return word;
    endfunction

    function automatic logic allDrained();
        for (int k = 0; k < `FUNNEL_WIDTH; k++) begin
            if (expQ[k].size() != 0 || pending[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Watchdog allowance of 20 cycles per row plus 10 per word the row can offer
    function automatic int runBudget();
        int total;
        total = 16;
        for (int r = 0; r < numRows; r++) begin
            total += 20 + int'(steps[r].cycles)
                   + 10 * int'(steps[r].cycles) * $countones(steps[r].mask);
        end
        return total;
    endfunction

    // Outputs settle long before the falling edge, so all sampling happens 1 ns after it
    task automatic sampleCycle(input stepRow r);
        expRecord rec;
        // Higher ports go first so words accepted together are ordered by pair priority
        for (int k = `FUNNEL_WIDTH - 1; k >= 0; k--) begin
            if (inEna[k] && inRdy[k]) begin
                rec.data    = inData[k];
                rec.cycle   = cycle;
                rec.timed   = r.timed;
                rec.ordered = r.ordered;
                expQ[k].push_back(rec);
                if (r.ordered) begin
                    orderQ.push_back(sourceTag'(k));
                end
                pending[k] = 1'b0;
                rowAccepted++;
            end
        end
        // A stalled output must hold its item until it is taken
        if (prevStall) begin
            if (!outEna) begin
                noteFailure("outEna dropped while outRdy was low");
            end else begin
                checkTag("outItem.tag", prevItem.tag, outItem.tag);
                checkWord("outItem.data", prevItem.data, outItem.data);
            end
        end
        if (outEna && outRdy) begin
            itemsOut++;
            if (expQ[outItem.tag].size() == 0) begin
                noteFailure($sformatf("output with tag %0d has no outstanding word", outItem.tag));
            end else begin
                rec = expQ[outItem.tag].pop_front();
                checkWord("outItem.data", rec.data, outItem.data);
                if (rec.ordered) begin
                    checkTag("outItem.tag", orderQ.pop_front(), outItem.tag);
                end
                if (rec.timed) begin
                    checkLatency("latency", 4, cycle - rec.cycle);
                end
            end
        end
        prevStall = outEna && !outRdy;
        prevItem  = outItem;
    endtask

    // One clock cycle; an inactive step offers no new words and takes every output
    task automatic stepCycle(input stepRow r, input logic active);
        logic [7:0] offer;
        @(negedge CLK);
        offer = r.randomMask ? (r.mask & 8'($random(seed))) : r.mask;
        for (int k = 0; k < `FUNNEL_WIDTH; k++) begin
            // A word stays on the port until the queue takes it
            if (active && offer[k] && !pending[k]) begin
                pendWord[k] = makeWord(k, r.seedMix);
                pending[k]  = 1'b1;
            end
            inEna[k] = pending[k];
            if (pending[k]) begin
                inData[k] = pendWord[k];
            end
        end
        if (!active || r.rdy == rdyAlways) begin
            outRdy = 1'b1;
        end else if (r.rdy == rdyNever) begin
            outRdy = 1'b0;
        end else begin
            outRdy = 1'($random(seed));
        end
        #1;
        sampleCycle(r);
        cycle++;
    endtask

    initial begin
        int testErrors;
        seed = 32'h1ec716da;
        reset = 1'b1;
        outRdy = 1'b0;
        for (int k = 0; k < `FUNNEL_WIDTH; k++) begin
            inEna[k] = 1'b0;
            inData[k] = '0;
            pending[k] = 1'b0;
            pendWord[k] = '0;
            seq[k] = 0;
        end
        cycle = 0;
        checks = 0;
        errors = 0;
        itemsOut = 0;
        prevStall = 1'b0;
        prevItem = '0;
        testName[0] = "single-port latency";
        testName[1] = "all ports at once";
        testName[2] = "pair priority";
        testName[3] = "back-pressure capacity";
        testName[4] = "random back-pressure";
        // Each row holds test, mask, random mask, data mix, outRdy, cycles, timed, ordered,
        // count check, accepted words and drain
        for (int k = 0; k < 8; k++) begin
            steps[k] = '{3'd0, 8'(1 << k), 1'b0, 32'h1000_0000, rdyAlways, 8'd1,
                         1'b1, 1'b1, 1'b1, queueCount'(1), 1'b1};
        end
        steps[8]  = '{3'd1, 8'hff, 1'b0, 32'h2200_0000, rdyAlways, 8'd16,
                      1'b0, 1'b0, 1'b0, queueCount'(0), 1'b1};
        steps[9]  = '{3'd2, 8'hc0, 1'b0, 32'h3300_0000, rdyNever, 8'd1,
                      1'b0, 1'b1, 1'b1, queueCount'(2), 1'b1};
        steps[10] = '{3'd3, 8'h01, 1'b0, 32'h4400_0000, rdyNever, 8'd12,
                      1'b0, 1'b0, 1'b1, queueCount'(7), 1'b1};
        steps[11] = '{3'd4, 8'hff, 1'b1, 32'h5500_0000, rdyRandom, 8'd60,
                      1'b0, 1'b0, 1'b0, queueCount'(0), 1'b0};
        steps[12] = '{3'd4, 8'h3c, 1'b1, 32'h6600_0000, rdyRandom, 8'd40,
                      1'b0, 1'b0, 1'b0, queueCount'(0), 1'b1};

        repeat (16) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        #1;
        // The design is empty after reset with nothing offered and every port ready
        testErrors = errors;
        if (outEna !== 1'b0) begin
            noteFailure("outEna is high right after reset");
        end
        for (int k = 0; k < `FUNNEL_WIDTH; k++) begin
            if (inRdy[k] !== 1'b1) begin
                noteFailure($sformatf("inRdy[%0d] is low right after reset", k));
            end
        end
        $display("Test reset state finished with %0d errors", errors - testErrors);

        testErrors = errors;
        for (int r = 0; r < numRows; r++) begin
            rowAccepted = 0;
            for (int c = 0; c < int'(steps[r].cycles); c++) begin
                stepCycle(steps[r], 1'b1);
            end
            if (steps[r].countAccepts) begin
                checkCount("accepted words", steps[r].expAccepted, queueCount'(rowAccepted));
            end
            // Drain waits on the DUT until every accepted word has come out
            if (steps[r].drain) begin
                while (!allDrained()) begin
                    stepCycle(steps[r], 1'b0);
                end
            end
            if (r == numRows - 1 || steps[r + 1].testId != steps[r].testId) begin
                $display("Test %s finished with %0d errors", testName[steps[r].testId],
                         errors - testErrors);
                testErrors = errors;
            end
        end

        $display("Tests done with %0d checks, %0d errors and %0d items out",
                 checks, errors, itemsOut);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        int budget;
        #1;
        budget = runBudget();
        repeat (budget) @(posedge CLK);
        $display("The run timed out after %0d clock cycles before all tests ended", budget);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* hdl/funnelTop.sv */
// Funnel top level that puts a queue on every producer port ahead of the merge tree
`timescale 1ns/1ns
`include "funnel_settings.svh"

module funnelTop import funnelPkg::*; (
    input  logic      CLK,
    input  logic      reset,
    // Producer ports
    input  logic      inEna  [`FUNNEL_WIDTH],
    input  dataWord   inData [`FUNNEL_WIDTH],
    output logic      inRdy  [`FUNNEL_WIDTH],
    // Merged and tagged output stream
    output logic      outEna,
    output funnelItem outItem,
    input  logic      outRdy
);

    // Queue heads, each presented to one leaf of the tree
    logic      headEna  [`FUNNEL_WIDTH];
    funnelItem headItem [`FUNNEL_WIDTH];
    logic      headRdy  [`FUNNEL_WIDTH];

    for (genvar k = 0; k < `FUNNEL_WIDTH; k++) begin : port
        enqQueue i_enqQueue (
            .CLK      (CLK),
            .reset    (reset),
            .inEna    (inEna[k]),
            .inData   (inData[k]),
            .inRdy    (inRdy[k]),
            .headEna  (headEna[k]),
            .headItem (headItem[k]),
            .headRdy  (headRdy[k])
        );
    end

    // Leaf k of the tree is port k, so the final tag is the port index
    funnelTree i_funnelTree (
        .CLK      (CLK),
        .reset    (reset),
        .leafEna  (headEna),
        .leafItem (headItem),
        .leafRdy  (headRdy),
        .rootEna  (outEna),
        .rootItem (outItem),
        .rootRdy  (outRdy)
    );

endmodule

/* hdl/funnelTree.sv */
// Funnel merge tree that chains registered levels from the leaf ports to one root link
`timescale 1ns/1ns
`include "funnel_settings.svh"

module funnelTree import funnelPkg::*; (
    input  logic      CLK,
    input  logic      reset,
    // One link per producer queue
    input  logic      leafEna  [`FUNNEL_WIDTH],
    input  funnelItem leafItem [`FUNNEL_WIDTH],
    output logic      leafRdy  [`FUNNEL_WIDTH],
    // Merged stream out of the last level
    output logic      rootEna,
    output funnelItem rootItem,
    input  logic      rootRdy
);

    // One level per tag bit, three for eight ports
    localparam int levelCount = $clog2(`FUNNEL_WIDTH);

    for (genvar i = 0; i < levelCount; i++) begin : level
        // Each level halves the number of links
        localparam int pairs = `FUNNEL_WIDTH >> (i + 1);

        logic      ena  [pairs];
        funnelItem item [pairs];
        logic      rdy  [pairs];

        if (i == 0) begin : first
            // The bottom level reads the queue heads directly
            funnelLevel #(.pairCount(pairs), .levelIndex(i)) i_funnelLevel (
                .CLK        (CLK),
                .reset      (reset),
                .childEna   (leafEna),
                .childItem  (leafItem),
                .childRdy   (leafRdy),
                .parentEna  (ena),
                .parentItem (item),
                .parentRdy  (rdy)
            );
        end else begin : inner
            // Upper levels read the outputs of the level below
            funnelLevel #(.pairCount(pairs), .levelIndex(i)) i_funnelLevel (
                .CLK        (CLK),
                .reset      (reset),
                .childEna   (level[i-1].ena),
                .childItem  (level[i-1].item),
                .childRdy   (level[i-1].rdy),
                .parentEna  (ena),
                .parentItem (item),
                .parentRdy  (rdy)
            );
        end

        if (i == levelCount - 1) begin : root
            // The last level has a single link, which is the tree output
            assign rootEna  = ena[0];
            assign rootItem = item[0];
            assign rdy[0]   = rootRdy;
        end
    end

endmodule

/* hdl/funnelLevel.sv */
// Funnel merge level that registers one item per child pair, higher child first
`timescale 1ns/1ns

module funnelLevel import funnelPkg::*; #(
    parameter int pairCount  = 4,
    parameter int levelIndex = 0
) (
    input  logic      CLK,
    input  logic      reset,
    // Links from the level below, two per pair
    input  logic      childEna   [2*pairCount],
    input  funnelItem childItem  [2*pairCount],
    output logic      childRdy   [2*pairCount],
    // Links toward the level above, one per pair
    output logic      parentEna  [pairCount],
    output funnelItem parentItem [pairCount],
    input  logic      parentRdy  [pairCount]
);

    for (genvar j = 0; j < pairCount; j++) begin : pair
        logic      hiEna;
        logic      loEna;
        logic      canLoad;
        logic      heldValid;
        funnelItem heldItem;
        funnelItem nextItem;

        assign hiEna = childEna[2*j+1];
        assign loEna = childEna[2*j];

        // The register takes a new item when it is empty or its item leaves now
        assign canLoad = !heldValid || parentRdy[j];

        // Fixed priority, the higher child always wins the pair
        // The lower child only gets Rdy while its neighbour is idle
        assign childRdy[2*j+1] = canLoad;
        assign childRdy[2*j]   = canLoad && !hiEna;

        // Winner's item with this level's tag bit marking which side it came from
        always_comb begin
            nextItem = hiEna ? childItem[2*j+1] : childItem[2*j];
            nextItem.tag[levelIndex] = hiEna;
        end

        always_ff @(posedge CLK) begin
            if (reset) begin
                heldValid <= 1'b0;
            end else if (canLoad) begin
                // Empties when the held item leaves and neither child offers one
                heldValid <= hiEna || loEna;
            end
        end

        // Payload register, only loaded on an actual transfer
        always_ff @(posedge CLK) begin
            if (canLoad && (hiEna || loEna)) begin
                heldItem <= nextItem;
            end
        end

        assign parentEna[j]  = heldValid;
        assign parentItem[j] = heldItem;
    end

endmodule

/* hdl/enqQueue.sv */
// Per-port entry queue that buffers producer words and offers them to the merge tree
`timescale 1ns/1ns
`include "funnel_settings.svh"

module enqQueue import funnelPkg::*; (
    input  logic      CLK,
    input  logic      reset,
    // Producer side of the queue
    input  logic      inEna,
    input  dataWord   inData,
    output logic      inRdy,
    // Oldest entry toward the first merge level
    output logic      headEna,
    output funnelItem headItem,
    input  logic      headRdy
);

    // Pointer width for the circular buffer, kept at one bit for a single entry
    localparam int ptrBits = (`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1;

    dataWord            mem [`QUEUE_DEPTH];
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] wrPtr;
    queueCount          count;
    logic               push;
    logic               pop;

    // Space freed by a pop in the same cycle is not offered to the producer
    // so inRdy only looks at the stored count
    assign inRdy   = (count != queueCount'(`QUEUE_DEPTH));
    assign headEna = (count != '0);

    assign push = inEna && inRdy;
    assign pop  = headEna && headRdy;

    // Words leave the queue untagged, the merge levels write the source bits
    assign headItem.tag  = '0;
    assign headItem.data = mem[rdPtr];

    // Storage is written on every accepted word and never cleared
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap explicitly, so the depth need not be a power of two
            if (push) begin
                wrPtr <= (wrPtr == ptrBits'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrBits'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/funnelPkg.sv */
// Funnel types shared by the queues, the merge levels and the top level
`include "funnel_settings.svh"

package funnelPkg;

    // One payload word as the producer hands it in
    typedef logic [`DATA_WIDTH-1:0] dataWord;

    // Index of the producer that sent an item
    // Each merge level fills in one bit of it on the way to the root
    typedef logic [$clog2(`FUNNEL_WIDTH)-1:0] sourceTag;

    // Item as it moves through the tree, tag in the upper bits
    typedef struct packed {
        sourceTag tag;
        dataWord  data;
    } funnelItem;

    // Queue occupancy, one bit wider than needed for an index so a full queue fits
    typedef logic [$clog2(`QUEUE_DEPTH + 1)-1:0] queueCount;

endpackage

/* hdl/funnel_settings.svh */
// Funnel settings that size the producer ports, payload words and per-port queues
`ifndef FUNNEL_SETTINGS_SVH
`define FUNNEL_SETTINGS_SVH

// Number of producer ports feeding the tree
// It must be a power of two because every merge level halves the link count
`define FUNNEL_WIDTH 8

// Width of one payload word in bits
`define DATA_WIDTH 32

// Entries held by each per-port queue before the producer sees back-pressure
`define QUEUE_DEPTH 4

`endif
